// File: include/ray_defs.svh
`ifndef RAY_DEFS_SVH
`define RAY_DEFS_SVH

// ****************************************
// Fixed point formats
// ****************************************

`define COORD_W 16 // Q8.8 coordinate
`define FRAC 8
`define COEF_W 40 // Scale 2^16 plus headroom

// ****************************************
// Object radii at scale 2^16
// ****************************************

`define SPHERE_RAD_SQ 262144 // Radius 2.0
`define CYL_RAD_SQ 65536 // Radius 1.0

`define FIFO_DEPTH 4

`endif

// File: verilog/ray_pkg.sv
`include "ray_defs.svh"

package ray_pkg;

  typedef struct packed {
    logic signed [`COORD_W-1:0] x;
    logic signed [`COORD_W-1:0] y;
    logic signed [`COORD_W-1:0] z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_t;

  // Axis is unit length for a cylinder and ignored for a sphere
  typedef struct packed {
    vec3_t center;
    vec3_t axis;
    logic  is_cylinder;
  } obj_t;

  // a*t^2 + 2h*t + c = 0, all words at scale 2^16
  typedef struct packed {
    logic signed [`COEF_W-1:0] a;
    logic signed [`COEF_W-1:0] h;
    logic signed [`COEF_W-1:0] c;
  } coef_t;

  typedef struct packed {
    logic signed [23:0] t; // Q16.8
    logic               undef;
  } hit_t;

endpackage

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic aclk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr]; // Head is visible the cycle after a push
  assign count_next = count + CNT_W'(push) - CNT_W'(pop);

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count_next;
      in_ready <= (count_next != CNT_W'(DEPTH)); // Registered full flag
    end
  end

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  // Registered ready must track the count so a full buffer never takes a push
  a_no_push_full: assert property (@(posedge aclk) disable iff (!rst_n)
    push |-> (count != CNT_W'(DEPTH)));

endmodule

// File: verilog/ray_coeff.sv
`timescale 1ns/1ps
`include "ray_defs.svh"

module ray_coeff (
  input  logic            aclk,
  input  logic            rst_n,
  input  logic            ray_valid,
  output logic            ray_ready,
  input  ray_pkg::ray_t   ray,
  input  logic            obj_valid,
  output logic            obj_ready,
  input  ray_pkg::obj_t   obj,
  output logic            coef_valid,
  input  logic            coef_ready,
  output ray_pkg::coef_t  coef
);

  logic run;
  logic advance;
  logic accept;
  logic v1;
  logic v2;
  logic v3;

  ray_pkg::vec3_t s1_oc;
  ray_pkg::vec3_t s1_d;
  ray_pkg::vec3_t s1_ca;
  logic s1_cyl;

  logic signed [`COEF_W-1:0] s2_dd;
  logic signed [`COEF_W-1:0] s2_ocd;
  logic signed [`COEF_W-1:0] s2_ococ;
  logic signed [`COEF_W-1:0] s2_dca;
  logic signed [`COEF_W-1:0] s2_occa;
  logic s2_cyl;

  ray_pkg::coef_t coef_next;

  // Q8.8 dot product at scale 2^16
  function automatic logic signed [`COEF_W-1:0] dot3(ray_pkg::vec3_t u, ray_pkg::vec3_t v);
    return u.x * v.x + u.y * v.y + u.z * v.z;
  endfunction

  // Product of two 2^16 words, brought back to 2^16
  function automatic logic signed [`COEF_W-1:0] fx_mul(logic signed [`COEF_W-1:0] p,
                                                       logic signed [`COEF_W-1:0] q);
    logic signed [2*`COEF_W-1:0] full;
    full = p * q;
    return full[`COEF_W+2*`FRAC-1:2*`FRAC];
  endfunction

  assign advance = !v3 || coef_ready;
  assign accept = run && advance && ray_valid && obj_valid;
  assign ray_ready = accept; // Both streams move together
  assign obj_ready = accept;
  assign coef_valid = v3;

  // ****************************************
  // Stage 3 combine
  // ****************************************

  always_comb begin
    if (s2_cyl) begin
      // Drop the components along the axis
      coef_next.a = s2_dd - fx_mul(s2_dca, s2_dca);
      coef_next.h = s2_ocd - fx_mul(s2_occa, s2_dca);
      coef_next.c = s2_ococ - fx_mul(s2_occa, s2_occa) - `CYL_RAD_SQ;
    end else begin
      coef_next.a = s2_dd;
      coef_next.h = s2_ocd;
      coef_next.c = s2_ococ - `SPHERE_RAD_SQ;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      run <= 1'b0;
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      run <= 1'b1;
      if (advance) begin
        v1 <= accept;
        v2 <= v1;
        v3 <= v2;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      s1_oc.x <= ray.origin.x - obj.center.x; // Stage 1
      s1_oc.y <= ray.origin.y - obj.center.y;
      s1_oc.z <= ray.origin.z - obj.center.z;
      s1_d <= ray.dir;
      s1_ca <= obj.axis;
      s1_cyl <= obj.is_cylinder;
      s2_dd <= dot3(s1_d, s1_d); // Stage 2
      s2_ocd <= dot3(s1_oc, s1_d);
      s2_ococ <= dot3(s1_oc, s1_oc);
      s2_dca <= dot3(s1_d, s1_ca);
      s2_occa <= dot3(s1_oc, s1_ca);
      s2_cyl <= s1_cyl;
      coef <= coef_next;
    end
  end

  a_coef_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    (coef_valid && !coef_ready) |=> (coef_valid && $stable(coef)));

endmodule

// File: verilog/quad_solve.sv
`timescale 1ns/1ps
`include "ray_defs.svh"

module quad_solve (
  input  logic           aclk,
  input  logic           rst_n,
  input  logic           coef_valid,
  output logic           coef_ready,
  input  ray_pkg::coef_t coef,
  output logic           hit_valid,
  input  logic           hit_ready,
  output ray_pkg::hit_t  hit
);

  typedef enum logic [2:0] {
    S_IDLE, S_CHECK, S_SQRT, S_PREP, S_DIV, S_DONE
  } state_t;

  state_t state;
  logic [5:0] cnt;

  logic signed [`COEF_W-1:0] a_q;
  logic signed [`COEF_W-1:0] h_q;
  logic signed [`COEF_W-1:0] c_q;
  logic signed [79:0] disc;
  logic no_hit;

  logic [79:0] rad;
  logic [43:0] rem_q;
  logic [39:0] root;
  logic [43:0] sq_rem_sh;
  logic [43:0] sq_trial;
  logic sq_ok;

  logic signed [51:0] num;
  logic neg;
  logic [63:0] mag;
  logic ovf;
  logic neg_q;
  logic [63:0] drem;
  logic [63:0] dvs;
  logic [23:0] quo;
  logic [23:0] quo_next;
  logic div_ok;

  ray_pkg::hit_t hit_q;

  // Signed Q16.8 from a quotient magnitude clipped to 24 bits
  function automatic logic signed [23:0] sat_t(logic n, logic [24:0] m);
    if (n) begin
      if (m > 25'd8388608) return 24'sh800000;
      return -m[23:0];
    end
    if (m > 25'd8388607) return 24'sh7fffff;
    return m[23:0];
  endfunction

  assign coef_ready = (state == S_IDLE);
  assign hit_valid = (state == S_DONE);
  assign hit = hit_q;

  assign disc = h_q * h_q - a_q * c_q;
  assign no_hit = (disc < 0) || (a_q <= 0);

  // ****************************************
  // Square root takes two radicand bits per cycle
  // ****************************************

  assign sq_rem_sh = {rem_q[41:0], rad[79:78]};
  assign sq_trial = {2'b00, root, 2'b01};
  assign sq_ok = (sq_rem_sh >= sq_trial);

  always_comb begin
    logic signed [51:0] h_ext;
    logic signed [51:0] s_ext;
    h_ext = h_q;
    s_ext = {12'b0, root};
    num = (52'sd0 - h_ext - s_ext) <<< `FRAC; // (-h - s) * 2^8
    neg = num[51];
    mag = {12'b0, neg ? -num : num};
    ovf = (mag >= ({24'b0, a_q} << 24)); // Quotient would not fit 24 bits
  end

  assign div_ok = (drem >= dvs);
  assign quo_next = {quo[22:0], div_ok};

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        S_IDLE: if (coef_valid) state <= S_CHECK;
        S_CHECK: begin
          state <= no_hit ? S_DONE : S_SQRT;
          cnt <= '0;
        end
        S_SQRT: begin
          if (cnt == 6'd39) state <= S_PREP;
          cnt <= cnt + 6'd1;
        end
        S_PREP: begin
          state <= ovf ? S_DONE : S_DIV;
          cnt <= '0;
        end
        S_DIV: begin
          if (cnt == 6'd23) state <= S_DONE;
          cnt <= cnt + 6'd1;
        end
        S_DONE: if (hit_ready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    case (state)
      S_IDLE: begin
        a_q <= coef.a;
        h_q <= coef.h;
        c_q <= coef.c;
      end
      S_CHECK: begin
        rad <= disc;
        rem_q <= '0;
        root <= '0;
        hit_q.t <= '0;
        hit_q.undef <= no_hit;
      end
      S_SQRT: begin
        rad <= rad << 2;
        rem_q <= sq_ok ? sq_rem_sh - sq_trial : sq_rem_sh;
        root <= {root[38:0], sq_ok};
      end
      S_PREP: begin
        drem <= mag;
        dvs <= {24'b0, a_q} << 23; // First quotient bit is 2^23
        quo <= '0;
        neg_q <= neg;
        if (ovf) hit_q.t <= sat_t(neg, 25'h1000000);
      end
      S_DIV: begin
        drem <= div_ok ? drem - dvs : drem;
        dvs <= dvs >> 1;
        quo <= quo_next;
        if (cnt == 6'd23) hit_q.t <= sat_t(neg_q, {1'b0, quo_next});
      end
      default: ;
    endcase
  end

  // An undef result follows the check, any other one the end of the divide
  a_no_early_hit: assert property (@(posedge aclk) disable iff (!rst_n)
    $rose(hit_valid) |-> (hit.undef ? ($past(state) == S_CHECK) :
      ($past(state) == S_PREP || ($past(state) == S_DIV && $past(cnt) == 6'd23))));

endmodule

// File: verilog/ray_intersect_top.sv
`timescale 1ns/1ps
`include "ray_defs.svh"

module ray_intersect_top (
  input  logic          aclk,
  input  logic          rst_n,
  input  logic          ray_valid,
  output logic          ray_ready,
  input  ray_pkg::ray_t ray,
  input  logic          obj_valid,
  output logic          obj_ready,
  input  ray_pkg::obj_t obj,
  output logic          hit_valid,
  input  logic          hit_ready,
  output ray_pkg::hit_t hit
);

  logic coef_valid;
  logic coef_ready;
  ray_pkg::coef_t coef;
  logic sq_valid; // Coefficient buffer to solver
  logic sq_ready;
  ray_pkg::coef_t sq_coef;
  logic res_valid; // Solver to result buffer
  logic res_ready;
  ray_pkg::hit_t res;

  ray_coeff i_coeff (
    .aclk(aclk), .rst_n(rst_n),
    .ray_valid(ray_valid), .ray_ready(ray_ready), .ray(ray),
    .obj_valid(obj_valid), .obj_ready(obj_ready), .obj(obj),
    .coef_valid(coef_valid), .coef_ready(coef_ready), .coef(coef)
  );

  stream_fifo #(.T(ray_pkg::coef_t), .DEPTH(`FIFO_DEPTH)) i_coef_buf (
    .aclk(aclk), .rst_n(rst_n),
    .in_valid(coef_valid), .in_ready(coef_ready), .in_data(coef),
    .out_valid(sq_valid), .out_ready(sq_ready), .out_data(sq_coef)
  );

  quad_solve i_solve (
    .aclk(aclk), .rst_n(rst_n),
    .coef_valid(sq_valid), .coef_ready(sq_ready), .coef(sq_coef),
    .hit_valid(res_valid), .hit_ready(res_ready), .hit(res)
  );

  stream_fifo #(.T(ray_pkg::hit_t), .DEPTH(`FIFO_DEPTH)) i_hit_buf (
    .aclk(aclk), .rst_n(rst_n),
    .in_valid(res_valid), .in_ready(res_ready), .in_data(res),
    .out_valid(hit_valid), .out_ready(hit_ready), .out_data(hit)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  input  logic rst_req,
  output logic aclk,
  output logic rst_n
);

  logic por_n;

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk; // 100 ns period
  end

  initial begin
    por_n = 1'b0;
    repeat (5) @(posedge aclk);
    por_n <= 1'b1;
  end

  assign rst_n = por_n && !rst_req; // Power-on reset or a requested mid-run reset

endmodule

// File: tests/tb_ray_intersect.sv
`timescale 1ns/1ps
`include "ray_defs.svh"

module tb_ray_intersect;

  localparam int TIMEOUT = 5000; // Cycles allowed for any single wait

  logic aclk;
  logic rst_n;
  logic rst_req;
  logic ray_valid;
  logic ray_ready;
  ray_pkg::ray_t ray;
  logic obj_valid;
  logic obj_ready;
  ray_pkg::obj_t obj;
  logic hit_valid;
  logic hit_ready;
  ray_pkg::hit_t hit;

  ray_pkg::hit_t exp_q[$];
  logic [31:0] rng;
  logic [31:0] bp_rng;
  int bp_mode; // 0 ready, 1 random stretches, 2 held low
  int bp_left;
  string cur_test;
  int errors;
  int test_errors;
  int results;
  int total_results;
  int tests_run;
  int tests_failed;
  bit aborted;

  tb_clock i_clk (.rst_req(rst_req), .aclk(aclk), .rst_n(rst_n));

  ray_intersect_top i_dut (
    .aclk(aclk), .rst_n(rst_n),
    .ray_valid(ray_valid), .ray_ready(ray_ready), .ray(ray),
    .obj_valid(obj_valid), .obj_ready(obj_ready), .obj(obj),
    .hit_valid(hit_valid), .hit_ready(hit_ready), .hit(hit)
  );

  // ****************************************
  // Random numbers and vectors
  // ****************************************

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_range(int lo, int hi);
    rng = xorshift32(rng);
    return lo + int'(rng % 32'(hi - lo + 1));
  endfunction

  function automatic int rand_sign();
    return (rand_range(0, 1) == 0) ? -1 : 1;
  endfunction

  function automatic ray_pkg::vec3_t rand_vec(int lim);
    ray_pkg::vec3_t u;
    u.x = 16'(rand_range(-lim, lim));
    u.y = 16'(rand_range(-lim, lim));
    u.z = 16'(rand_range(-lim, lim));
    return u;
  endfunction

  function automatic ray_pkg::vec3_t axis_vec(int idx, int v);
    ray_pkg::vec3_t u;
    u = '0;
    case (idx)
      0: u.x = 16'(v);
      1: u.y = 16'(v);
      default: u.z = 16'(v);
    endcase
    return u;
  endfunction

  // p + k*q per component
  function automatic ray_pkg::vec3_t vec_add_scaled(ray_pkg::vec3_t p, ray_pkg::vec3_t q, int k);
    ray_pkg::vec3_t u;
    u.x = p.x + 16'(k * q.x);
    u.y = p.y + 16'(k * q.y);
    u.z = p.z + 16'(k * q.z);
    return u;
  endfunction

  task automatic random_pair(output ray_pkg::ray_t r, output ray_pkg::obj_t o);
    o.is_cylinder = (rand_range(0, 1) == 1);
    o.center = rand_vec(1024);
    o.axis = axis_vec(rand_range(0, 2), rand_sign() * 256);
    r.origin = rand_vec(2048);
    r.dir = rand_vec(512);
  endtask

  // ****************************************
  // Reference model
  // ****************************************

  function automatic ray_pkg::hit_t expected_hit(ray_pkg::ray_t r, ray_pkg::obj_t o);
    logic signed [79:0] oc [3];
    logic signed [79:0] d [3];
    logic signed [79:0] ca [3];
    logic signed [79:0] dd;
    logic signed [79:0] ocd;
    logic signed [79:0] ococ;
    logic signed [79:0] dca;
    logic signed [79:0] occa;
    logic signed [79:0] a;
    logic signed [79:0] h;
    logic signed [79:0] c;
    logic signed [79:0] disc;
    logic signed [79:0] s;
    logic signed [79:0] num;
    logic signed [79:0] q;
    logic [95:0] lo;
    logic [95:0] hi;
    logic [95:0] mid;
    ray_pkg::hit_t res;
    oc[0] = r.origin.x - o.center.x;
    oc[1] = r.origin.y - o.center.y;
    oc[2] = r.origin.z - o.center.z;
    d[0] = r.dir.x;
    d[1] = r.dir.y;
    d[2] = r.dir.z;
    ca[0] = o.axis.x;
    ca[1] = o.axis.y;
    ca[2] = o.axis.z;
    dd = 0;
    ocd = 0;
    ococ = 0;
    dca = 0;
    occa = 0;
    for (int i = 0; i < 3; i++) begin
      dd += d[i] * d[i];
      ocd += oc[i] * d[i];
      ococ += oc[i] * oc[i];
      dca += d[i] * ca[i];
      occa += oc[i] * ca[i];
    end
    if (o.is_cylinder) begin
      a = dd - ((dca * dca) >>> (2 * `FRAC)); // Axial parts removed
      h = ocd - ((occa * dca) >>> (2 * `FRAC));
      c = ococ - ((occa * occa) >>> (2 * `FRAC)) - `CYL_RAD_SQ;
    end else begin
      a = dd;
      h = ocd;
      c = ococ - `SPHERE_RAD_SQ;
    end
    res.t = '0;
    res.undef = 1'b1;
    disc = h * h - a * c;
    if (disc >= 0 && a > 0) begin
      lo = '0;
      hi = 96'h100_0000_0000;
      for (int i = 0; i < 48; i++) begin
        mid = (lo + hi + 96'd1) >> 1;
        if (lo < hi) begin
          if (mid * mid <= 96'(disc)) begin
            lo = mid;
          end else begin
            hi = mid - 96'd1;
          end
        end
      end
      s = lo[79:0]; // Largest s with s*s <= disc
      num = (-h - s) <<< `FRAC;
      q = num / a; // Truncates toward zero
      if (q > 80'sd8388607) begin
        q = 80'sd8388607;
      end else if (q < -80'sd8388608) begin
        q = -80'sd8388608;
      end
      res.t = q[23:0];
      res.undef = 1'b0;
    end
    return res;
  endfunction

  // ****************************************
  // Checks and handshakes
  // ****************************************

  task automatic check_hit(string name, ray_pkg::hit_t want, ray_pkg::hit_t got);
    if (got !== want) begin
      $display("[FAIL] %s: expected t=%0d undef=%0b, actual t=%0d undef=%0b",
               name, want.t, want.undef, got.t, got.undef);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(string name, string what, logic want, logic got);
    if (got !== want) begin
      $display("[FAIL] %s: %s expected %0b, actual %0b", name, what, want, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    aborted = 1'b1;
  endtask

  task automatic send_pair(ray_pkg::ray_t r, ray_pkg::obj_t o, int ray_gap, int obj_gap);
    int cyc;
    bit done;
    cyc = 0;
    done = 1'b0;
    ray <= r;
    obj <= o;
    while (!done) begin
      if (cyc >= ray_gap) ray_valid <= 1'b1;
      if (cyc >= obj_gap) obj_valid <= 1'b1;
      @(posedge aclk);
      done = ray_valid && obj_valid && ray_ready;
      check_flag(cur_test, "obj_ready", done, obj_ready); // Readies rise together on a transfer
      cyc++;
      if (!done && cyc > TIMEOUT) abort_run($sformatf("Timeout: pair not taken in %s", cur_test));
    end
    ray_valid <= 1'b0;
    obj_valid <= 1'b0;
  endtask

  task automatic drain();
    int cyc;
    cyc = 0;
    do begin
      @(negedge aclk);
      cyc++;
      if (cyc > TIMEOUT) abort_run($sformatf("Timeout: %0d results never arrived in %s",
                                             exp_q.size(), cur_test));
    end while (exp_q.size() != 0);
    repeat (3) @(posedge aclk); // Room for a stray extra result to show up
  endtask

  task automatic start_test(string name);
    cur_test = name;
    test_errors = 0;
    results = 0;
  endtask

  task automatic end_test();
    drain();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok, %0d results", cur_test, results);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors in %0d results", cur_test, test_errors, results);
    end
  endtask

  // Ends the run from a stalled wait
  initial begin
    wait (aborted);
    $display("Done: errors found");
    $finish;
  end

  // Expected values queued at acceptance
  always @(posedge aclk) begin
    ray_pkg::hit_t want;
    if (rst_n !== 1'b1) begin
      exp_q.delete(); // Reset drops pairs in flight
    end else begin
      if (ray_valid && ray_ready && obj_valid && obj_ready) begin
        exp_q.push_back(expected_hit(ray, obj));
      end
      if (hit_valid && hit_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected result in %s with no pair outstanding", cur_test);
          errors++;
          test_errors++;
        end else begin
          want = exp_q.pop_front();
          check_hit(cur_test, want, hit);
          results++;
          total_results++;
        end
      end
    end
  end

  // Low stretches of hit_ready run long
  always @(posedge aclk) begin
    if (bp_mode == 0) begin
      hit_ready <= 1'b1;
    end else if (bp_mode == 2) begin
      hit_ready <= 1'b0;
    end else if (bp_left > 0) begin
      bp_left <= bp_left - 1;
    end else begin
      bp_rng = xorshift32(bp_rng);
      hit_ready <= bp_rng[0];
      bp_left <= bp_rng[0] ? int'(bp_rng[3:1]) : 50 + int'(bp_rng[13:5]);
    end
  end

  initial begin
    ray_pkg::ray_t r;
    ray_pkg::obj_t o;
    ray_pkg::vec3_t d;
    int idx;
    int cyc;
    rng = 32'h0400efe6;
    bp_rng = xorshift32(32'h0400efe6);
    bp_mode = 0;
    bp_left = 0;
    errors = 0;
    total_results = 0;
    tests_run = 0;
    tests_failed = 0;
    cur_test = "reset";
    ray_valid = 1'b0;
    obj_valid = 1'b0;
    ray = '0;
    obj = '0;
    hit_ready = 1'b1;
    rst_req = 1'b0;
    cyc = 0;
    while (rst_n !== 1'b1) begin
      @(posedge aclk);
      cyc++;
      if (cyc > 20) abort_run("Reset was never released");
    end

    start_test("sphere_hit"); // Rays aimed at the centre
    for (int n = 0; n < 20; n++) begin
      o = '0;
      o.center = rand_vec(1024);
      d = rand_vec(256);
      if (d == '0) d.x = 16'sd256;
      r.dir = d;
      r.origin = vec_add_scaled(o.center, d, -rand_range(3, 5));
      send_pair(r, o, 0, 0);
    end
    end_test();

    start_test("sphere_miss"); // Offset of 2.5 to 4.0 across the ray
    for (int n = 0; n < 20; n++) begin
      o = '0;
      o.center = rand_vec(1024);
      idx = rand_range(0, 2);
      r.dir = axis_vec(idx, rand_sign() * rand_range(128, 256));
      d = axis_vec((idx + 1) % 3, rand_sign() * rand_range(640, 1024));
      r.origin = vec_add_scaled(vec_add_scaled(o.center, d, 1), r.dir, -rand_range(2, 5));
      send_pair(r, o, 0, 0);
    end
    end_test();

    start_test("cylinder");
    for (int n = 0; n < 30; n++) begin
      idx = rand_range(0, 2);
      o.is_cylinder = 1'b1;
      o.center = rand_vec(1024);
      o.axis = axis_vec(idx, rand_sign() * 256);
      r.origin = rand_vec(2048);
      if (n % 5 == 0) begin
        r.dir = axis_vec(idx, rand_sign() * rand_range(64, 512)); // Parallel to the axis
      end else begin
        r.dir = rand_vec(512);
      end
      send_pair(r, o, 0, 0);
    end
    end_test();

    start_test("random_mix");
    for (int n = 0; n < 200; n++) begin
      random_pair(r, o);
      send_pair(r, o, rand_range(0, 3), rand_range(0, 3));
    end
    end_test();

    start_test("back_pressure");
    bp_mode <= 1;
    for (int n = 0; n < 40; n++) begin
      random_pair(r, o);
      send_pair(r, o, rand_range(0, 2), rand_range(0, 2));
    end
    end_test();
    bp_mode <= 0;

    start_test("mid_reset");
    bp_mode <= 2;
    for (int n = 0; n < 3; n++) begin
      random_pair(r, o);
      send_pair(r, o, 0, 0);
    end
    repeat (100) @(posedge aclk);
    rst_req <= 1'b1;
    repeat (2) @(posedge aclk);
    rst_req <= 1'b0;
    bp_mode <= 0;
    @(posedge aclk);
    check_flag(cur_test, "hit_valid after reset", 1'b0, hit_valid);
    for (int n = 0; n < 10; n++) begin
      random_pair(r, o);
      send_pair(r, o, rand_range(0, 1), rand_range(0, 1));
    end
    end_test();

    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             tests_run, tests_failed, total_results, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
verilog/ray_pkg.sv
verilog/stream_fifo.sv
verilog/ray_coeff.sv
verilog/quad_solve.sv
verilog/ray_intersect_top.sv
tests/tb_clock.sv
tests/tb_ray_intersect.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_ray_intersect \
  && ./obj_dir/Vtb_ray_intersect > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
